//--- include/vred_settings.svh
// Vector reduction settings
`ifndef VRED_SETTINGS_SVH
`define VRED_SETTINGS_SVH

// Vector register length in bits
`define VRED_VLEN 128

// Scalar start value and result width
`define VRED_SCALAR_W 64

// Tree depth, log2 of VLEN/8
`define VRED_LEVELS 4

`endif

//--- hw/vred_pkg.sv
// Vector reduction types
`include "vred_settings.svh"

package vred_pkg;

    typedef enum logic [1:0] {
        SEW_8  = 2'b00,
        SEW_16 = 2'b01,
        SEW_32 = 2'b10,
        SEW_64 = 2'b11
    } sew_e;

    typedef enum logic [1:0] {
        RED_SUM = 2'b00,
        RED_AND = 2'b01,
        RED_OR  = 2'b10,
        RED_XOR = 2'b11
    } red_op_e;

    typedef logic [`VRED_VLEN-1:0]     vec_t;
    typedef logic [`VRED_VLEN/8-1:0]   mask_t;   // One bit per 8-bit slot
    typedef logic [`VRED_SCALAR_W-1:0] scalar_t;

    function automatic int sew_width(sew_e sew);
        case (sew)
            SEW_8:   return 8;
            SEW_16:  return 16;
            SEW_32:  return 32;
            default: return 64;
        endcase
    endfunction

    function automatic scalar_t sew_mask(sew_e sew);
        return {`VRED_SCALAR_W{1'b1}} >> (`VRED_SCALAR_W - sew_width(sew));
    endfunction

    // Pairwise combine, result wraps modulo 2^SEW
    function automatic scalar_t red_combine(red_op_e op, sew_e sew, scalar_t a, scalar_t b);
        scalar_t res;
        case (op)
            RED_SUM: res = a + b;
            RED_AND: res = a & b;
            RED_OR:  res = a | b;
            default: res = a ^ b;
        endcase
        return res & sew_mask(sew);
    endfunction

endpackage

//--- hw/vred_input_stage.sv
// Reduction input register
`timescale 1ns/100ps
`include "vred_settings.svh"

module vred_input_stage
    import vred_pkg::*;
(
    input  logic    clk_i,
    input  logic    rstn_i,
    input  logic    in_valid_i,
    input  red_op_e op_i,
    input  sew_e    sew_i,
    input  vec_t    vec_i,
    input  mask_t   mask_i,
    input  scalar_t scalar_i,
    output logic    valid_o,
    output red_op_e op_o,
    output sew_e    sew_o,
    output vec_t    vec_o,
    output mask_t   mask_o,
    output scalar_t scalar_o
);

    localparam int SLOTS = `VRED_VLEN / 8;

    int    elem_cnt;
    mask_t live_mask;

    assign elem_cnt = `VRED_VLEN / sew_width(sew_i);

    // Only the first VLEN/SEW mask bits name real elements
    always_comb begin
        for (int i = 0; i < SLOTS; i++) begin
            live_mask[i] = (i < elem_cnt);
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= in_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_valid_i) begin
            op_o     <= op_i;
            sew_o    <= sew_i;
            vec_o    <= vec_i;
            mask_o   <= mask_i & live_mask;
            scalar_o <= scalar_i;
        end
    end

    a_ctrl_known: assert property (@(posedge clk_i) disable iff (!rstn_i)
        in_valid_i |-> !$isunknown({op_i, sew_i}));

endmodule

//--- hw/vred_tree_level.sv
// Reduction tree level
`timescale 1ns/100ps
`include "vred_settings.svh"

module vred_tree_level
    import vred_pkg::*;
#(
    parameter int LEVEL = 0
) (
    input  logic    clk_i,
    input  logic    rstn_i,
    input  logic    valid_i,
    input  red_op_e op_i,
    input  sew_e    sew_i,
    input  vec_t    vec_i,
    input  mask_t   mask_i,
    input  scalar_t scalar_i,
    output logic    valid_o,
    output red_op_e op_o,
    output sew_e    sew_o,
    output vec_t    vec_o,
    output mask_t   mask_o,
    output scalar_t scalar_o
);

    // Most pairs this level can see, reached at SEW 8
    localparam int PAIRS = (`VRED_VLEN / 16) >> LEVEL;

    // Live elements entering a level, never below one
    function automatic int live_count(sew_e sew, int lvl);
        int n;
        n = (`VRED_VLEN / sew_width(sew)) >> lvl;
        return (n < 1) ? 1 : n;
    endfunction

    int      elem_w;
    int      live_in;
    scalar_t elem_mask;
    vec_t    vec_d;
    mask_t   mask_d;

    assign elem_w    = sew_width(sew_i);
    assign live_in   = live_count(sew_i, LEVEL);
    assign elem_mask = sew_mask(sew_i);

    always_comb begin
        scalar_t lo;
        scalar_t hi;
        scalar_t res;
        logic    act;
        vec_d  = '0;
        mask_d = '0;
        lo     = '0;
        hi     = '0;
        res    = '0;
        act    = 1'b0;
        if (live_in < 2) begin
            // Tree already done for this SEW
            vec_d     = vec_t'(vec_i[`VRED_SCALAR_W-1:0] & elem_mask);
            mask_d[0] = mask_i[0];
        end else begin
            for (int j = 0; j < PAIRS; j++) begin
                lo = scalar_t'(vec_i >> (2 * j * elem_w)) & elem_mask;
                hi = scalar_t'(vec_i >> ((2 * j + 1) * elem_w)) & elem_mask;
                case ({mask_i[2*j+1], mask_i[2*j]})
                    2'b00: begin
                        res = '0;
                        act = 1'b0;
                    end
                    2'b01: begin
                        res = lo;
                        act = 1'b1;
                    end
                    2'b10: begin
                        res = hi;
                        act = 1'b1;
                    end
                    default: begin
                        res = red_combine(op_i, sew_i, lo, hi);
                        act = 1'b1;
                    end
                endcase
                vec_d     = vec_d | (vec_t'(res) << (j * elem_w));
                mask_d[j] = act;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            op_o     <= op_i;
            sew_o    <= sew_i;
            vec_o    <= vec_d;
            mask_o   <= mask_d;
            scalar_o <= scalar_i;     // Start value rides along
        end
    end

    // Relies on the input stage trimming the mask as well as on this level
    a_mask_range: assert property (@(posedge clk_i) disable iff (!rstn_i)
        valid_o |-> ((mask_o >> live_count(sew_o, LEVEL + 1)) == '0));

endmodule

//--- hw/vred_scalar_merge.sv
// Scalar merge and result register
`timescale 1ns/100ps
`include "vred_settings.svh"

module vred_scalar_merge
    import vred_pkg::*;
(
    input  logic    clk_i,
    input  logic    rstn_i,
    input  logic    valid_i,
    input  red_op_e op_i,
    input  sew_e    sew_i,
    input  vec_t    vec_i,
    input  mask_t   mask_i,
    input  scalar_t scalar_i,
    output logic    out_valid_o,
    output scalar_t result_o
);

    scalar_t elem0;
    scalar_t scalar_lo;
    scalar_t merged;

    assign elem0     = vec_i[`VRED_SCALAR_W-1:0] & sew_mask(sew_i);
    assign scalar_lo = scalar_i & sew_mask(sew_i);

    // Empty reduction leaves the start value alone
    assign merged = mask_i[0] ? red_combine(op_i, sew_i, elem0, scalar_lo) : scalar_lo;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            out_valid_o <= 1'b0;
            result_o    <= '0;
        end else begin
            out_valid_o <= valid_i;
            if (valid_i) begin
                result_o <= merged;   // Held between items
            end
        end
    end

    a_zero_ext: assert property (@(posedge clk_i) disable iff (!rstn_i)
        out_valid_o |-> ((result_o & ~sew_mask($past(sew_i))) == '0));

endmodule

//--- hw/vred_top.sv
// Vector reduction unit
`timescale 1ns/100ps
`include "vred_settings.svh"

module vred_top
    import vred_pkg::*;
(
    input  logic    clk_i,
    input  logic    rstn_i,
    input  logic    in_valid_i,
    input  red_op_e op_i,
    input  sew_e    sew_i,
    input  vec_t    vec_i,
    input  mask_t   mask_i,
    input  scalar_t scalar_i,
    output logic    out_valid_o,
    output scalar_t result_o
);

    // Index k feeds tree level k, last index feeds the merge
    logic    valid_s  [`VRED_LEVELS+1];
    red_op_e op_s     [`VRED_LEVELS+1];
    sew_e    sew_s    [`VRED_LEVELS+1];
    vec_t    vec_s    [`VRED_LEVELS+1];
    mask_t   mask_s   [`VRED_LEVELS+1];
    scalar_t scalar_s [`VRED_LEVELS+1];

    vred_input_stage input_stage_i (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .in_valid_i (in_valid_i),
        .op_i       (op_i),
        .sew_i      (sew_i),
        .vec_i      (vec_i),
        .mask_i     (mask_i),
        .scalar_i   (scalar_i),
        .valid_o    (valid_s[0]),
        .op_o       (op_s[0]),
        .sew_o      (sew_s[0]),
        .vec_o      (vec_s[0]),
        .mask_o     (mask_s[0]),
        .scalar_o   (scalar_s[0])
    );

    for (genvar k = 0; k < `VRED_LEVELS; k++) begin : g_level
        vred_tree_level #(.LEVEL(k)) tree_level_i (
            .clk_i    (clk_i),
            .rstn_i   (rstn_i),
            .valid_i  (valid_s[k]),
            .op_i     (op_s[k]),
            .sew_i    (sew_s[k]),
            .vec_i    (vec_s[k]),
            .mask_i   (mask_s[k]),
            .scalar_i (scalar_s[k]),
            .valid_o  (valid_s[k+1]),
            .op_o     (op_s[k+1]),
            .sew_o    (sew_s[k+1]),
            .vec_o    (vec_s[k+1]),
            .mask_o   (mask_s[k+1]),
            .scalar_o (scalar_s[k+1])
        );
    end

    vred_scalar_merge scalar_merge_i (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .valid_i     (valid_s[`VRED_LEVELS]),
        .op_i        (op_s[`VRED_LEVELS]),
        .sew_i       (sew_s[`VRED_LEVELS]),
        .vec_i       (vec_s[`VRED_LEVELS]),
        .mask_i      (mask_s[`VRED_LEVELS]),
        .scalar_i    (scalar_s[`VRED_LEVELS]),
        .out_valid_o (out_valid_o),
        .result_o    (result_o)
    );

endmodule

//--- tb/vred_clk_gen.sv
// Testbench clock and reset
`timescale 1ns/100ps

module vred_clk_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 3,
    parameter int RELEASE_DLY  = 2
) (
    output logic clk_o,
    output logic rstn_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

    initial begin
        rstn_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #RELEASE_DLY rstn_o = 1'b1;   // Released off the clock edge
    end

endmodule

//--- tb/vred_tb.sv
// Vector reduction testbench
`timescale 1ns/100ps
`include "vred_settings.svh"

module vred_tb
    import vred_pkg::*;
();

    localparam int LATENCY   = 6;
    localparam int MARGIN    = 50;
    localparam int RESET_CYC = 3;
    localparam int DRIVE_DLY = 2;
    localparam int SEED      = 32'h62b7f526;

    logic    clk;
    logic    rstn;
    logic    in_valid;
    red_op_e op;
    sew_e    sew;
    vec_t    vec;
    mask_t   mask;
    scalar_t scalar;
    logic    out_valid;
    scalar_t result;

    scalar_t exp_q[$];          // Expected results in arrival order
    int      due_q[$];          // Edge that samples each result
    int      cycle       = 0;
    int      items_sent  = 0;
    int      idle_cycles = 0;
    int      n_checked   = 0;

    vred_clk_gen #(
        .PERIOD_NS    (20),
        .RESET_CYCLES (RESET_CYC),
        .RELEASE_DLY  (DRIVE_DLY)
    ) clk_gen_i (
        .clk_o  (clk),
        .rstn_o (rstn)
    );

    vred_top vred_top_i (
        .clk_i       (clk),
        .rstn_i      (rstn),
        .in_valid_i  (in_valid),
        .op_i        (op),
        .sew_i       (sew),
        .vec_i       (vec),
        .mask_i      (mask),
        .scalar_i    (scalar),
        .out_valid_o (out_valid),
        .result_o    (result)
    );

    function automatic int elem_bits(sew_e s);
        case (s)
            SEW_8:   return 8;
            SEW_16:  return 16;
            SEW_32:  return 32;
            default: return 64;
        endcase
    endfunction

    function automatic scalar_t elem_ones(sew_e s);
        if (elem_bits(s) == 64) begin
            return '1;
        end
        return (scalar_t'(1) << elem_bits(s)) - 1;
    endfunction

    // Fold active elements into the start value, modulo 2^SEW
    function automatic scalar_t ref_reduce(red_op_e o, sew_e s, vec_t v, mask_t m, scalar_t sc);
        int      w;
        scalar_t ones;
        scalar_t acc;
        scalar_t e;
        w    = elem_bits(s);
        ones = elem_ones(s);
        acc  = sc & ones;
        for (int i = 0; i < `VRED_VLEN / w; i++) begin
            if (m[i]) begin
                e = scalar_t'(v >> (i * w)) & ones;
                case (o)
                    RED_SUM: acc = (acc + e) & ones;
                    RED_AND: acc = acc & e;
                    RED_OR:  acc = acc | e;
                    default: acc = acc ^ e;
                endcase
            end
        end
        return acc;
    endfunction

    function automatic vec_t rand_vec();
        vec_t v;
        for (int i = 0; i < `VRED_VLEN / 32; i++) begin
            v[i*32 +: 32] = $urandom;
        end
        return v;
    endfunction

    function automatic scalar_t rand_scalar();
        return {$urandom, $urandom};
    endfunction

    task automatic stop_with_error(string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(string name, scalar_t got, scalar_t expected);
        if (got !== expected) begin
            stop_with_error($sformatf("[FAIL] %0t ns %s: got 0x%h, expected 0x%h",
                                      $time, name, got, expected));
        end
    endtask

    task automatic send_item(red_op_e o, sew_e s, vec_t v, mask_t m, scalar_t sc,
                             scalar_t expected);
        @(posedge clk);
        #DRIVE_DLY;
        in_valid = 1'b1;
        op       = o;
        sew      = s;
        vec      = v;
        mask     = m;
        scalar   = sc;
        exp_q.push_back(expected);
        due_q.push_back(cycle + 1 + LATENCY);   // Accepted on the next edge
        items_sent++;
    endtask

    task automatic idle(int n);
        repeat (n) begin
            @(posedge clk);
            #DRIVE_DLY;
            in_valid = 1'b0;
            idle_cycles++;
        end
    endtask

    // Cycle counter and run limit
    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle > RESET_CYC + items_sent + idle_cycles + LATENCY + MARGIN) begin
            stop_with_error($sformatf("Timeout after %0d cycles with %0d results outstanding",
                                      cycle, exp_q.size()));
        end
    end

    // Outputs are read mid-cycle, the value the next edge samples
    always @(negedge clk) begin
        scalar_t expected;
        int      due;
        if (out_valid) begin
            if (exp_q.size() == 0) begin
                stop_with_error($sformatf("out_valid_o high at %0t ns with no item in flight",
                                          $time));
            end else begin
                expected = exp_q.pop_front();
                due      = due_q.pop_front();
                if (cycle + 1 != due) begin
                    stop_with_error($sformatf("Result arrived at edge %0d, expected edge %0d",
                                              cycle + 1, due));
                end else begin
                    check_value("result_o", result, expected);
                    n_checked++;
                end
            end
        end else begin
            if (due_q.size() != 0 && due_q[0] <= cycle + 1) begin
                stop_with_error($sformatf("No result at edge %0d for an item due then",
                                          due_q[0]));
            end else if (n_checked == 0) begin
                check_value("result_o", result, '0);   // Still the reset value
            end
        end
    end

    initial begin
        int      n;
        red_op_e o;
        sew_e    s;
        vec_t    v;
        mask_t   m;
        scalar_t sc;
        in_valid  = 1'b0;
        op        = RED_SUM;
        sew       = SEW_8;
        vec       = '0;
        mask      = '0;
        scalar    = '0;
        void'($urandom(SEED));
        wait (rstn === 1'b1);
        idle(2);

        // Every opcode at every SEW, all elements active
        for (int oi = 0; oi < 4; oi++) begin
            for (int si = 0; si < 4; si++) begin
                o  = red_op_e'(oi);
                s  = sew_e'(si);
                v  = rand_vec();
                sc = rand_scalar();
                m  = '1;
                send_item(o, s, v, m, sc, ref_reduce(o, s, v, m, sc));
            end
        end
        idle(3);

        // Empty, single-element and random masks with short gaps
        for (int i = 0; i < 48; i++) begin
            o  = red_op_e'($urandom_range(3));
            s  = sew_e'($urandom_range(3));
            n  = `VRED_VLEN / elem_bits(s);
            v  = rand_vec();
            sc = rand_scalar();
            case (i % 4)
                0:       m = '0;
                1:       m = mask_t'(1) << $urandom_range(n - 1);
                default: m = mask_t'($urandom);
            endcase
            send_item(o, s, v, m, sc, ref_reduce(o, s, v, m, sc));
            idle($urandom_range(1));
        end
        idle(2);

        // Back-to-back stream
        for (int i = 0; i < 24; i++) begin
            o  = red_op_e'($urandom_range(3));
            s  = sew_e'($urandom_range(3));
            v  = rand_vec();
            sc = rand_scalar();
            m  = mask_t'($urandom);
            send_item(o, s, v, m, sc, ref_reduce(o, s, v, m, sc));
        end
        idle(1);

        // n+1 copies of 2^SEW-1 add up to 2^SEW-(n+1)
        for (int si = 0; si < 4; si++) begin
            s = sew_e'(si);
            n = `VRED_VLEN / elem_bits(s);
            send_item(RED_SUM, s, '1, '1, '1, (elem_ones(s) - scalar_t'(n)) & elem_ones(s));
        end
        idle(1);

        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);

        if (n_checked == items_sent) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            stop_with_error($sformatf("Only %0d of %0d results were checked",
                                      n_checked, items_sent));
        end
    end

endmodule

//--- src.f
+incdir+include
hw/vred_pkg.sv
hw/vred_input_stage.sv
hw/vred_tree_level.sv
hw/vred_scalar_merge.sv
hw/vred_top.sv
tb/vred_clk_gen.sv
tb/vred_tb.sv

//--- Makefile
SRCS := $(filter-out +%,$(shell cat src.f))
BIN  := obj_dir/Vvred_tb

.PHONY: all run clean

all: run

$(BIN): src.f $(SRCS) include/vred_settings.svh
	verilator --binary --timing --assert --top-module vred_tb -f src.f

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir
